//--- Bender.yml
package:
  name: eth_core

sources:
  - include_dirs:
      - common
    files:
      - common/eth_pkg.sv
      - verilog/eth_dual_clock_ram.sv
      - eth_tx/eth_tx.sv
      - eth_rx/eth_rx.sv
      - verilog/eth_core.sv

  - target: test
    include_dirs:
      - common
    files:
      - verification/eth_core_tb.sv

//--- common/eth_defines.svh
`ifndef ETH_DEFINES_SVH
`define ETH_DEFINES_SVH

// Host address width, the top bit selects the data window
`define ETH_ADDR_W 12

// Register map
`define ETH_STATUS    0
`define ETH_CONTROL   1
`define ETH_DUMMY     2
`define ETH_TX_NBYTES 3
`define ETH_RX_NBYTES 4

// 2048 bytes per frame buffer
`define ETH_BUF_ADDR_W 11

// Count of 0x55 bytes before the delimiter
`define ETH_PREAMBLE_BYTES 7

`endif

//--- common/eth_pkg.sv
`include "eth_defines.svh"

package eth_pkg;

   // Host bus address
   typedef logic [`ETH_ADDR_W-1:0] eth_addr_t;

   // Byte count or buffer address
   typedef logic [`ETH_BUF_ADDR_W-1:0] eth_count_t;

   // One MII data nibble
   typedef logic [3:0] mii_nibble_t;

endpackage

//--- eth_rx/eth_rx.sv
`timescale 1ns/1ps

module eth_rx (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 recv_req,
   input  eth_pkg::eth_count_t  nbytes,
   output logic                 ready,
   input  logic                 RX_CLK,
   input  eth_pkg::mii_nibble_t RX_DATA,
   input  logic                 RX_DV,
   output logic                 wr,
   output eth_pkg::eth_count_t  wr_addr,
   output logic [7:0]           wr_data
);
   import eth_pkg::*;

   typedef enum logic [1:0] {s_idle, s_sfd, s_data} rx_state_t;

   logic        recv_tgl;
   eth_count_t  nbytes_q;
   logic [1:0]  recv_sync;
   logic        recv_seen;
   logic        start;
   rx_state_t   state;
   eth_count_t  len;
   eth_count_t  cnt;
   logic        hi;
   mii_nibble_t low;
   mii_nibble_t last;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         recv_tgl <= 1'b0;
      end else if (recv_req) begin
         recv_tgl <= ~recv_tgl;
      end
   end

   always_ff @(posedge clk) begin
      if (recv_req) begin
         nbytes_q <= nbytes;
      end
   end

   always_ff @(posedge RX_CLK, posedge rst) begin
      if (rst) begin
         recv_sync <= 2'b00;
         recv_seen <= 1'b0;
      end else begin
         recv_sync <= {recv_sync[0], recv_tgl};
         recv_seen <= recv_sync[1];
      end
   end

   assign start = recv_sync[1] ^ recv_seen;

   // Previous valid nibble for the 5 then D match
   always_ff @(posedge RX_CLK) begin
      last <= RX_DV ? RX_DATA : 4'h0;
      if (state == s_data && !hi) begin
         low <= RX_DATA;
      end
   end

   always_ff @(posedge RX_CLK, posedge rst) begin
      if (rst) begin
         state   <= s_idle;
         ready   <= 1'b1;
         len     <= '0;
         cnt     <= '0;
         hi      <= 1'b0;
         wr      <= 1'b0;
         wr_addr <= '0;
         wr_data <= '0;
      end else begin
         wr <= 1'b0;
         case (state)
            s_idle: begin
               ready <= 1'b1;
               hi    <= 1'b0;
               if (start) begin
                  ready <= 1'b0;
                  state <= s_sfd;
                  len   <= nbytes_q;
                  cnt   <= '0;
               end
            end
            s_sfd: begin
               hi <= 1'b0;
               if (RX_DV && RX_DATA == 4'hd && last == 4'h5) begin
                  state <= s_data;
               end
            end
            s_data: begin
               if (!RX_DV) begin
                  // Frame ended early
                  state <= s_idle;
               end else begin
                  hi <= ~hi;
                  if (hi) begin
                     wr      <= 1'b1;
                     wr_data <= {RX_DATA, low};
                     wr_addr <= cnt;
                     cnt     <= cnt + 1'b1;
                     if (cnt == len - 1'b1) begin
                        state <= s_idle;
                     end
                  end
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

endmodule

//--- eth_tx/eth_tx.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module eth_tx (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 send_req,
   input  eth_pkg::eth_count_t  nbytes,
   output logic                 ready,
   input  logic                 TX_CLK,
   output eth_pkg::eth_count_t  rd_addr,
   input  logic [7:0]           rd_data,
   output logic                 TX_EN,
   output eth_pkg::mii_nibble_t TX_DATA
);
   import eth_pkg::*;

   typedef enum logic [1:0] {s_idle, s_pre, s_sfd, s_data} tx_state_t;

   logic       send_tgl;
   eth_count_t nbytes_q;
   logic [1:0] send_sync;
   logic       send_seen;
   logic       start;
   tx_state_t  state;
   eth_count_t len;
   eth_count_t byte_cnt;
   logic       hi;
   logic [7:0] cur;

   // Request toggle in the host domain
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         send_tgl <= 1'b0;
      end else if (send_req) begin
         send_tgl <= ~send_tgl;
      end
   end

   always_ff @(posedge clk) begin
      if (send_req) begin
         nbytes_q <= nbytes;
      end
   end

   always_ff @(posedge TX_CLK, posedge rst) begin
      if (rst) begin
         send_sync <= 2'b00;
         send_seen <= 1'b0;
      end else begin
         send_sync <= {send_sync[0], send_tgl};
         send_seen <= send_sync[1];
      end
   end

   // Only acted on when idle
   assign start = send_sync[1] ^ send_seen;

   // Next byte is taken from the RAM at every high nibble
   always_ff @(posedge TX_CLK) begin
      if (hi && (state == s_sfd || state == s_data)) begin
         cur <= rd_data;
      end
   end

   always_ff @(posedge TX_CLK, posedge rst) begin
      if (rst) begin
         state    <= s_idle;
         ready    <= 1'b1;
         TX_EN    <= 1'b0;
         TX_DATA  <= '0;
         rd_addr  <= '0;
         len      <= '0;
         byte_cnt <= '0;
         hi       <= 1'b0;
      end else begin
         case (state)
            s_idle: begin
               TX_EN   <= 1'b0;
               TX_DATA <= '0;
               hi      <= 1'b0;
               ready   <= 1'b1;
               if (start) begin
                  ready    <= 1'b0;
                  state    <= s_pre;
                  len      <= nbytes_q;
                  byte_cnt <= '0;
                  rd_addr  <= '0;
               end
            end
            s_pre: begin
               TX_EN   <= 1'b1;
               TX_DATA <= 4'h5;
               hi      <= ~hi;
               if (hi) begin
                  if (byte_cnt == `ETH_PREAMBLE_BYTES - 1) begin
                     state    <= s_sfd;
                     byte_cnt <= '0;
                  end else begin
                     byte_cnt <= byte_cnt + 1'b1;
                  end
               end
            end
            s_sfd: begin
               TX_EN   <= 1'b1;
               TX_DATA <= hi ? 4'hd : 4'h5;
               hi      <= ~hi;
               if (hi) begin
                  state   <= s_data;
                  rd_addr <= rd_addr + 1'b1;
               end
            end
            s_data: begin
               // Low nibble first
               TX_EN   <= 1'b1;
               TX_DATA <= hi ? cur[7:4] : cur[3:0];
               hi      <= ~hi;
               if (hi) begin
                  rd_addr <= rd_addr + 1'b1;
                  if (byte_cnt == len - 1'b1) begin
                     state <= s_idle;
                  end else begin
                     byte_cnt <= byte_cnt + 1'b1;
                  end
               end
            end
            default: state <= s_idle;
         endcase
      end
   end

endmodule

//--- files.f
+incdir+common
common/eth_pkg.sv
verilog/eth_dual_clock_ram.sv
eth_tx/eth_tx.sv
eth_rx/eth_rx.sv
verilog/eth_core.sv
verification/eth_core_tb.sv

//--- verification/eth_core_tb.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module eth_core_tb;
   import eth_pkg::*;

   // Table row with the payload length, receiver arm, second send while busy
   // and the expected TX_EN cycle count of 2 * (8 + len)
   typedef struct packed {
      eth_count_t len;
      logic       arm;
      logic       resend;
      eth_count_t en_cycles;
   } frame_t;

   localparam int n_frames   = 7;
   localparam int poll_limit = 10000;

   localparam eth_addr_t addr_status    = eth_addr_t'(`ETH_STATUS);
   localparam eth_addr_t addr_control   = eth_addr_t'(`ETH_CONTROL);
   localparam eth_addr_t addr_dummy     = eth_addr_t'(`ETH_DUMMY);
   localparam eth_addr_t addr_tx_nbytes = eth_addr_t'(`ETH_TX_NBYTES);
   localparam eth_addr_t addr_rx_nbytes = eth_addr_t'(`ETH_RX_NBYTES);

   logic        clk;
   logic        rst;
   logic        sel;
   logic        we;
   eth_addr_t   addr;
   logic [31:0] data_in;
   logic [31:0] data_out;
   logic        mii_clk;
   logic        eth_resetn;
   logic        tx_en;
   mii_nibble_t tx_data;

   frame_t      frames [n_frames];
   eth_addr_t   quiet_addrs [6];
   logic [7:0]  payload [2048];
   logic [7:0]  rx_model [2048];
   eth_count_t  last_rx_len;
   mii_nibble_t exp_nibbles [$];
   eth_count_t  en_count;
   logic [31:0] rng;
   int unsigned clk_cycles;

   // MII looped back from transmitter to receiver
   eth_core DUT (
      .clk        (clk),
      .rst        (rst),
      .sel        (sel),
      .we         (we),
      .addr       (addr),
      .data_in    (data_in),
      .data_out   (data_out),
      .ETH_RESETN (eth_resetn),
      .RX_CLK     (mii_clk),
      .RX_DATA    (tx_data),
      .RX_DV      (tx_en),
      .TX_CLK     (mii_clk),
      .TX_EN      (tx_en),
      .TX_DATA    (tx_data)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      mii_clk = 1'b0;
      forever #20 mii_clk = ~mii_clk;
   end

   always @(posedge clk) begin
      clk_cycles <= clk_cycles + 1;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_nibble(input string name, input mii_nibble_t got,
                               input mii_nibble_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_count(input string name, input eth_count_t got, input eth_count_t exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%03h, expected 0x%03h", name, got, exp);
         abort_run();
      end
   endtask

   // Write lands on the second rising edge
   task automatic host_write(input eth_addr_t a, input logic [31:0] d);
      @(posedge clk);
      sel     <= 1'b1;
      we      <= 1'b1;
      addr    <= a;
      data_in <= d;
      @(posedge clk);
      sel <= 1'b0;
      we  <= 1'b0;
   endtask

   // Register reads are combinational
   task automatic host_read(input eth_addr_t a, output logic [31:0] d);
      @(posedge clk);
      sel  <= 1'b1;
      we   <= 1'b0;
      addr <= a;
      @(negedge clk);
      d = data_out;
   endtask

   // Receive buffer byte shows up one clk after the address
   task automatic buffer_read(input eth_count_t idx, output logic [7:0] b);
      @(posedge clk);
      sel  <= 1'b1;
      we   <= 1'b0;
      addr <= {1'b1, idx};
      @(posedge clk);
      @(negedge clk);
      b = data_out[7:0];
   endtask

   task automatic wait_status_bit(input int idx, input logic level, input string name,
                                  input logic rx_hold);
      logic [31:0] status;
      int          polls;
      polls = 0;
      do begin
         host_read(addr_status, status);
         if (rx_hold) begin
            check_word("status rx_ready", {31'd0, status[1]}, 32'd1);
         end
         polls++;
         if (status[idx] !== level && polls > poll_limit) begin
            $display("Timeout while waiting for %s to become %0d", name, level);
            abort_run();
         end
      end while (status[idx] !== level);
   endtask

   // Every TX_EN cycle must carry the next expected nibble
   always @(negedge mii_clk) begin : tx_monitor
      mii_nibble_t want;
      if (tx_en === 1'b1) begin
         if (exp_nibbles.size() == 0) begin
            $display("TX_EN is high although no nibble of the frame is left");
            abort_run();
         end else begin
            want = exp_nibbles.pop_front();
            check_nibble("TX_DATA", tx_data, want);
            en_count = en_count + 1'b1;
         end
      end
   end

   task automatic run_frame(input frame_t f);
      logic [7:0] got;
      int         i;
      for (i = 0; i < f.len; i++) begin
         rng = xorshift32(rng);
         payload[i] = rng[7:0];
         host_write({1'b1, eth_count_t'(i)}, {24'd0, payload[i]});
      end
      host_write(addr_tx_nbytes, {21'd0, f.len});

      // Preamble and delimiter nibbles come before the payload
      exp_nibbles.delete();
      for (i = 0; i < 2 * `ETH_PREAMBLE_BYTES + 1; i++) begin
         exp_nibbles.push_back(4'h5);
      end
      exp_nibbles.push_back(4'hd);
      for (i = 0; i < f.len; i++) begin
         exp_nibbles.push_back(payload[i][3:0]);
         exp_nibbles.push_back(payload[i][7:4]);
      end
      en_count = '0;

      if (f.arm) begin
         host_write(addr_rx_nbytes, {21'd0, f.len});
         host_write(addr_control, 32'h2);
         wait_status_bit(1, 1'b0, "rx_ready", 1'b0);
      end
      host_write(addr_control, 32'h1);
      wait_status_bit(0, 1'b0, "tx_ready", !f.arm);
      if (f.resend) begin
         host_write(addr_control, 32'h1);
      end
      wait_status_bit(0, 1'b1, "tx_ready", !f.arm);
      check_count("TX_EN cycles", en_count, f.en_cycles);

      if (f.arm) begin
         wait_status_bit(1, 1'b1, "rx_ready", 1'b0);
         for (i = 0; i < f.len; i++) begin
            rx_model[i] = payload[i];
         end
         last_rx_len = f.len;
      end
      // Unarmed frames leave the last received bytes in place
      for (i = 0; i < last_rx_len; i++) begin
         buffer_read(eth_count_t'(i), got);
         check_byte($sformatf("rx_buffer[0x%03h]", i), got, rx_model[i]);
      end
   endtask

   initial begin : main_flow
      logic [31:0] word;
      int unsigned rel;
      int          i;
      rst         = 1'b1;
      sel         = 1'b0;
      we          = 1'b0;
      addr        = '0;
      data_in     = '0;
      rng         = 32'h2f3;
      en_count    = '0;
      last_rx_len = '0;

      frames[0] = '{11'd1, 1'b1, 1'b0, 11'd18};
      frames[1] = '{11'd2, 1'b1, 1'b0, 11'd20};
      frames[2] = '{11'd17, 1'b1, 1'b1, 11'd50};
      frames[3] = '{11'd5, 1'b0, 1'b0, 11'd26};
      frames[4] = '{11'd64, 1'b1, 1'b0, 11'd144};
      frames[5] = '{11'd300, 1'b1, 1'b1, 11'd616};
      frames[6] = '{11'd40, 1'b0, 1'b1, 11'd96};
      quiet_addrs = '{addr_control, addr_tx_nbytes, addr_rx_nbytes,
                      12'h005, 12'h07f, 12'h7ff};

      repeat (16) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      rel = clk_cycles;
      check_word("TX_EN", {31'd0, tx_en}, 32'd0);
      check_word("ETH_RESETN", {31'd0, eth_resetn}, 32'd0);
      host_read(addr_status, word);
      check_word("status", word, 32'd0);

      i = 0;
      while (eth_resetn !== 1'b1) begin
         @(negedge clk);
         i++;
         if (i > 100) begin
            $display("Timeout while waiting for ETH_RESETN to rise");
            abort_run();
         end
      end
      if (clk_cycles - rel < 64 || clk_cycles - rel > 70) begin
         $display("ERROR ETH_RESETN: rose after 0x%0h clk cycles, expected 0x40 to 0x46",
                  clk_cycles - rel);
         abort_run();
      end
      wait_status_bit(0, 1'b1, "tx_ready", 1'b0);
      wait_status_bit(1, 1'b1, "rx_ready", 1'b0);
      host_read(addr_status, word);
      check_word("status", word, 32'h3);

      // Scratch register and unused addresses
      for (i = 0; i < 4; i++) begin
         rng = xorshift32(rng);
         host_write(addr_dummy, rng);
         host_read(addr_dummy, word);
         check_word("dummy", word, rng);
      end
      for (i = 0; i < 6; i++) begin
         host_read(quiet_addrs[i], word);
         check_word($sformatf("data_out at 0x%03h", quiet_addrs[i]), word, 32'd0);
      end

      for (i = 0; i < n_frames; i++) begin
         run_frame(frames[i]);
      end

      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- verilog/eth_core.sv
`timescale 1ns/1ps
`include "eth_defines.svh"

module eth_core (
   // Host bus
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 sel,
   input  logic                 we,
   input  eth_pkg::eth_addr_t   addr,
   input  logic [31:0]          data_in,
   output logic [31:0]          data_out,

   // MII
   output logic                 ETH_RESETN,
   input  logic                 RX_CLK,
   input  eth_pkg::mii_nibble_t RX_DATA,
   input  logic                 RX_DV,
   input  logic                 TX_CLK,
   output logic                 TX_EN,
   output eth_pkg::mii_nibble_t TX_DATA
);
   import eth_pkg::*;

   logic [31:0] dummy;
   eth_count_t  tx_nbytes;
   eth_count_t  rx_nbytes;

   // Write strobes from the decoder
   logic        ctrl_wr;
   logic        dummy_wr;
   logic        tx_nbytes_wr;
   logic        rx_nbytes_wr;
   logic        tx_buf_wr;
   logic        send_req;
   logic        recv_req;

   // Buffer links
   eth_count_t  tx_rd_addr;
   logic [7:0]  tx_rd_data;
   logic        rx_wr;
   eth_count_t  rx_wr_addr;
   logic [7:0]  rx_wr_data;
   logic [7:0]  rx_rd_data;

   // Ready levels and their synchronizers
   logic        tx_ready_mii;
   logic        rx_ready_mii;
   logic [1:0]  tx_ready_sync;
   logic [1:0]  rx_ready_sync;
   logic        tx_ready;
   logic        rx_ready;

   logic [5:0]  phy_rst_cnt;
   logic        phy_ready;

   always_comb begin
      ctrl_wr      = 1'b0;
      dummy_wr     = 1'b0;
      tx_nbytes_wr = 1'b0;
      rx_nbytes_wr = 1'b0;
      tx_buf_wr    = 1'b0;
      data_out     = '0;
      if (addr[`ETH_ADDR_W-1]) begin
         // Data window
         tx_buf_wr = sel & we;
         data_out  = {24'd0, rx_rd_data};
      end else begin
         case (addr)
            `ETH_STATUS:    data_out = {30'd0, rx_ready, tx_ready};
            `ETH_CONTROL:   ctrl_wr = sel & we;
            `ETH_DUMMY: begin
               data_out = dummy;
               dummy_wr = sel & we;
            end
            `ETH_TX_NBYTES: tx_nbytes_wr = sel & we;
            `ETH_RX_NBYTES: rx_nbytes_wr = sel & we;
            default:        data_out = '0;
         endcase
      end
   end

   assign send_req = ctrl_wr & data_in[0];
   assign recv_req = ctrl_wr & data_in[1];

   always_ff @(posedge clk) begin
      if (dummy_wr) begin
         dummy <= data_in;
      end
      if (tx_nbytes_wr) begin
         tx_nbytes <= data_in[`ETH_BUF_ADDR_W-1:0];
      end
      if (rx_nbytes_wr) begin
         rx_nbytes <= data_in[`ETH_BUF_ADDR_W-1:0];
      end
   end

   // Ready levels into the host domain, held low until the PHY is out of reset
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         tx_ready_sync <= 2'b00;
         rx_ready_sync <= 2'b00;
         tx_ready      <= 1'b0;
         rx_ready      <= 1'b0;
      end else begin
         tx_ready_sync <= {tx_ready_sync[0], tx_ready_mii & phy_ready};
         rx_ready_sync <= {rx_ready_sync[0], rx_ready_mii & phy_ready};
         tx_ready      <= tx_ready_sync[1] & ETH_RESETN;
         rx_ready      <= rx_ready_sync[1] & ETH_RESETN;
      end
   end

   // PHY reset release after 64 host cycles
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         phy_rst_cnt <= '0;
         ETH_RESETN  <= 1'b0;
      end else if (phy_rst_cnt != 6'd63) begin
         phy_rst_cnt <= phy_rst_cnt + 1'b1;
      end else begin
         ETH_RESETN <= 1'b1;
      end
   end

   always_ff @(posedge RX_CLK, posedge rst) begin
      if (rst) begin
         phy_ready <= 1'b0;
      end else begin
         phy_ready <= 1'b1;
      end
   end

   eth_dual_clock_ram #(.DATA_W(8), .ADDR_W(`ETH_BUF_ADDR_W)) tx_buffer (
      .clk_a  (clk),
      .we_a   (tx_buf_wr),
      .addr_a (addr[`ETH_BUF_ADDR_W-1:0]),
      .data_a (data_in[7:0]),
      .clk_b  (TX_CLK),
      .addr_b (tx_rd_addr),
      .data_b (tx_rd_data)
   );

   eth_dual_clock_ram #(.DATA_W(8), .ADDR_W(`ETH_BUF_ADDR_W)) rx_buffer (
      .clk_a  (RX_CLK),
      .we_a   (rx_wr),
      .addr_a (rx_wr_addr),
      .data_a (rx_wr_data),
      .clk_b  (clk),
      .addr_b (addr[`ETH_BUF_ADDR_W-1:0]),
      .data_b (rx_rd_data)
   );

   eth_tx tx (
      .clk      (clk),
      .rst      (rst),
      .send_req (send_req),
      .nbytes   (tx_nbytes),
      .ready    (tx_ready_mii),
      .TX_CLK   (TX_CLK),
      .rd_addr  (tx_rd_addr),
      .rd_data  (tx_rd_data),
      .TX_EN    (TX_EN),
      .TX_DATA  (TX_DATA)
   );

   eth_rx rx (
      .clk      (clk),
      .rst      (rst),
      .recv_req (recv_req),
      .nbytes   (rx_nbytes),
      .ready    (rx_ready_mii),
      .RX_CLK   (RX_CLK),
      .RX_DATA  (RX_DATA),
      .RX_DV    (RX_DV),
      .wr       (rx_wr),
      .wr_addr  (rx_wr_addr),
      .wr_data  (rx_wr_data)
   );

endmodule

//--- verilog/eth_dual_clock_ram.sv
`timescale 1ns/1ps

module eth_dual_clock_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 11
) (
   // Write port
   input  logic              clk_a,
   input  logic              we_a,
   input  logic [ADDR_W-1:0] addr_a,
   input  logic [DATA_W-1:0] data_a,

   // Read port
   input  logic              clk_b,
   input  logic [ADDR_W-1:0] addr_b,
   output logic [DATA_W-1:0] data_b
);

   logic [DATA_W-1:0] mem [2**ADDR_W];

   always_ff @(posedge clk_a) begin
      if (we_a) begin
         mem[addr_a] <= data_a;
      end
   end

   // Registered read, one clk_b of latency
   always_ff @(posedge clk_b) begin
      data_b <= mem[addr_b];
   end

endmodule
